/* src/nes_bus_pkg.sv */
// Shared types and constants for a fixed 16-bit CPU map with NTSC and PAL timing only and no mirroring
package nes_bus_pkg;

	// Bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Master clock dividers
	localparam logic [3:0] CPU_DIV = 4'd12;             // Master clocks per CPU cycle
	localparam logic [2:0] PPU_DIV = 3'd4;              // Master clocks per PPU cycle
	localparam logic [2:0] PAL_STRETCH_PERIOD = 3'd5;   // CPU cycles per PAL group

	// Register map
	localparam logic [ADDR_W-1:0] SPRITE_DMA_REG = 16'h4014;  // Sprite DMA page trigger
	localparam logic [ADDR_W-1:0] SPRITE_PORT    = 16'h2004;  // PPU OAM data port
	localparam logic [ADDR_W-1:0] JOY1_REG       = 16'h4016;  // Strobe on write, pad 1 on read
	localparam logic [ADDR_W-1:0] JOY2_REG       = 16'h4017;  // Pad 2 on read
	localparam logic [ADDR_W-1:0] APU_BASE       = 16'h4000;  // First APU register
	localparam logic [ADDR_W-1:0] APU_END        = 16'h4018;  // One past the last APU register

	// CPU side bus cycle, held for a whole CPU cycle
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rnw;      // 1 for a read
	} cpu_bus_t;

	// Bus request from the DMA engine
	typedef struct packed {
		logic              enable;   // DMA owns the bus this cycle
		logic              read;     // 1 for a read, 0 for a write
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} dma_bus_t;

	// Enables and cycle state from the master clock
	typedef struct packed {
		logic cpu_ce;      // One clock per CPU cycle
		logic ppu_ce;      // One clock per PPU cycle
		logic odd_cycle;   // 1 on odd CPU cycles
		logic cpu_reset;   // Held until the first CPU tick
	} timing_t;

	// Page and offset halves of a CPU address
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} addr_split_t;

	// One address seen whole or as page plus offset
	typedef union packed {
		logic [ADDR_W-1:0] word;
		addr_split_t       part;
	} dma_addr_u;

endpackage

/* src/cycle_timer.sv */
// Assumes the master clock runs at 12x CPU and 4x PPU with PAL adding one PPU period every fifth CPU cycle
`timescale 1ns/1ns

module cycle_timer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [1:0]           sys_type,   // Bit 0 selects PAL
	output nes_bus_pkg::timing_t timing
);

	logic [3:0] div_cpu;         // Master clocks into the CPU cycle
	logic [2:0] div_ppu;         // Master clocks into the PPU cycle
	logic [2:0] pal_cnt;         // Position in the PAL group
	logic       first_ppu;       // No PPU tick yet since the last CPU tick
	logic       odd_cycle;       // Starts odd after reset
	logic       hold_reset;      // CPU reset stretch
	logic [1:0] last_sys_type;   // For realign on a mode change
	logic       cpu_ce;
	logic       ppu_ce;
	logic       stretch;         // CPU divider frozen this clock

	assign cpu_ce = (div_cpu == nes_bus_pkg::CPU_DIV);
	assign ppu_ce = (div_ppu == nes_bus_pkg::PPU_DIV);

	// Last cycle of a PAL group waits one PPU period before it counts
	assign stretch = (pal_cnt == nes_bus_pkg::PAL_STRETCH_PERIOD - 3'd1) && first_ppu;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu       <= 4'd1;
			div_ppu       <= 3'd1;
			pal_cnt       <= 3'd0;
			first_ppu     <= 1'b0;
			odd_cycle     <= 1'b1;
			hold_reset    <= 1'b1;
			last_sys_type <= sys_type;   // No realign right out of reset
		end else begin
			last_sys_type <= sys_type;

			if (last_sys_type != sys_type) begin
				// Mode change puts both dividers back in phase
				div_cpu   <= 4'd1;
				div_ppu   <= 3'd1;
				pal_cnt   <= 3'd0;
				first_ppu <= 1'b0;
			end else begin
				if (!stretch)
					div_cpu <= cpu_ce ? 4'd1 : div_cpu + 4'd1;
				div_ppu <= ppu_ce ? 3'd1 : div_ppu + 3'd1;

				if (cpu_ce)
					first_ppu <= 1'b1;   // CPU and PPU ticks coincide here
				else if (ppu_ce)
					first_ppu <= 1'b0;

				// Group counter runs in PAL only and stays at zero in NTSC
				if (cpu_ce && sys_type[0]) begin
					if (pal_cnt == nes_bus_pkg::PAL_STRETCH_PERIOD - 3'd1)
						pal_cnt <= 3'd0;
					else
						pal_cnt <= pal_cnt + 3'd1;
				end
			end

			if (cpu_ce) begin
				odd_cycle  <= !odd_cycle;   // Flips every CPU cycle
				hold_reset <= 1'b0;         // CPU leaves reset on its first tick
			end
		end
	end

	assign timing = '{
		cpu_ce:    cpu_ce,
		ppu_ce:    ppu_ce,
		odd_cycle: odd_cycle,
		cpu_reset: hold_reset
	};

	// Stretch and realign never produce back to back CPU ticks
	a_cpu_ce_single: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |=> !cpu_ce)
		else $error("cpu_ce high on two clocks in a row");

endmodule

/* src/dma_engine.sv */
// Sprite DMA copies one 256-byte page to the OAM port and lets a single DMC fetch steal an even slot
`timescale 1ns/1ns

module dma_engine (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_bus_pkg::timing_t  timing,
	input  logic                  sprite_trigger,   // One clock on a $4014 write
	input  logic                  cpu_rnw,          // CPU is in a read cycle
	input  logic [7:0]            cpu_wdata,        // Page number from the CPU
	input  logic [7:0]            bus_rdata,        // Byte read on the owned bus
	input  logic                  dmc_req,          // Level until acked
	input  logic [15:0]           dmc_addr,
	output nes_bus_pkg::dma_bus_t dma,
	output logic                  dmc_ack,
	output logic                  pause_cpu
);

	logic                  dmc_state;   // DMC fetch pending on the next even cycle
	logic [1:0]            spr_state;   // 00 idle, 01 waiting, 11 copying
	nes_bus_pkg::dma_addr_u src_addr;   // Sprite source page and offset
	logic [7:0]            last_val;    // Byte between read and write halves
	logic [8:0]            next_offset; // Offset plus carry out
	logic                  spr_active;
	logic                  even;

	assign even        = !timing.odd_cycle;
	assign spr_active  = spr_state[1];
	assign next_offset = {1'b0, src_addr.part.offset} + 9'd1;

	// Control state
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= 2'b00;
		end else begin
			if (timing.cpu_ce) begin
				// DMC grant on an even cycle while the CPU reads
				if (!dmc_state && dmc_req && cpu_rnw && even)
					dmc_state <= 1'b1;
				if (dmc_state && even)
					dmc_state <= 1'b0;   // Fetch done in this even slot
			end

			if (sprite_trigger) begin
				spr_state <= 2'b01;   // Halt CPU and wait for alignment
			end else if (timing.cpu_ce) begin
				if (spr_state == 2'b01 && cpu_rnw && timing.odd_cycle)
					spr_state <= 2'b11;   // Copy starts on the next even cycle
				if (spr_active && even && dmc_state)
					spr_state <= 2'b01;   // Read slot lost to DMC, next odd idles
				if (spr_active && timing.odd_cycle && next_offset[8])
					spr_state <= 2'b00;   // Last write of the page
			end
		end
	end

	// Source address and byte latch
	always_ff @(posedge clk) begin
		if (sprite_trigger) begin
			src_addr.part.page   <= cpu_wdata;
			src_addr.part.offset <= 8'h00;
		end else if (timing.cpu_ce && spr_active && timing.odd_cycle) begin
			src_addr.part.offset <= next_offset[7:0];   // Step after each write
		end

		if (timing.cpu_ce && spr_active && even)
			last_val <= bus_rdata;   // Sample at the end of the read half
	end

	assign dmc_ack   = dmc_state && even;
	assign pause_cpu = spr_state[0] || dmc_req;

	always_comb begin
		dma.enable = dmc_ack || spr_active;
		dma.read   = dmc_ack || (spr_active && even);
		dma.wdata  = last_val;
		if (dmc_ack)
			dma.addr = dmc_addr;            // DMC wins the even slot
		else if (even)
			dma.addr = src_addr.word;       // Sprite read
		else
			dma.addr = nes_bus_pkg::SPRITE_PORT;   // Sprite write
	end

	// Engine reads only on even cycles and writes only on odd ones
	a_read_phase: assert property (@(posedge clk) disable iff (reset)
		dma.enable |-> (dma.read == !timing.odd_cycle))
		else $error("DMA direction out of phase with odd_cycle");

	// DMC fetch never lands in an odd slot
	a_dmc_even: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> !timing.odd_cycle)
		else $error("dmc_ack on an odd cycle");

endmodule

/* src/cpu_bus_arbiter.sv */
// DMA takes the bus whenever it asks and every APU register other than the joypads reads as open bus
`timescale 1ns/1ns

module cpu_bus_arbiter (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_bus_pkg::cpu_bus_t cpu_bus,        // Request from the CPU
	input  nes_bus_pkg::dma_bus_t dma,            // Request from the DMA engine
	input  logic [7:0]            mem_rdata,
	input  logic [4:0]            joypad1_data,
	input  logic [4:0]            joypad2_data,
	output nes_bus_pkg::cpu_bus_t mem_bus,        // Bus after ownership
	output logic [7:0]            bus_rdata,      // Read data back to CPU and DMA
	output logic                  sprite_trigger,
	output logic [2:0]            joypad_out,
	output logic [1:0]            joypad_clock
);

	nes_bus_pkg::dma_addr_u bus_addr;   // Owned address
	logic                   bus_rd;
	logic                   bus_wr;
	logic                   apu_cs;     // Anywhere in $4000-$4017
	logic                   joy1_cs;
	logic                   joy2_cs;
	logic                   spr_wr;     // Write to the sprite DMA register
	logic                   spr_wr_q;   // Last clock's spr_wr for the edge
	logic [7:0]             open_bus;   // Last byte on the data bus
	logic [2:0]             joy_out;

	// DMA has priority over the CPU
	always_comb begin
		if (dma.enable) begin
			mem_bus.addr  = dma.addr;
			mem_bus.wdata = dma.wdata;
			mem_bus.rnw   = dma.read;
		end else begin
			mem_bus = cpu_bus;
		end
	end

	assign bus_addr.word = mem_bus.addr;
	assign bus_rd        = mem_bus.rnw;
	assign bus_wr        = !mem_bus.rnw;

	// Register decode on the owned address
	assign apu_cs  = (bus_addr.word >= nes_bus_pkg::APU_BASE) &&
	                 (bus_addr.word < nes_bus_pkg::APU_END);
	assign joy1_cs = (bus_addr.word == nes_bus_pkg::JOY1_REG);
	assign joy2_cs = (bus_addr.word == nes_bus_pkg::JOY2_REG);
	assign spr_wr  = (bus_addr.word == nes_bus_pkg::SPRITE_DMA_REG) && bus_wr;

	// Trigger fires once at the start of the write cycle
	assign sprite_trigger = spr_wr && !spr_wr_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_wr_q <= 1'b0;
			joy_out  <= 3'b000;
			open_bus <= 8'h00;
		end else begin
			spr_wr_q <= spr_wr;
			if (joy1_cs && bus_wr)
				joy_out <= mem_bus.wdata[2:0];   // Strobe bits
			open_bus <= bus_rdata;               // Tracks the bus every clock
		end
	end

	assign joypad_out   = joy_out;
	assign joypad_clock = {joy2_cs && bus_rd, joy1_cs && bus_rd};   // Clocks the pad shifters

	// Read data mux
	always_comb begin
		if (reset) begin
			bus_rdata = 8'h00;
		end else if (apu_cs) begin
			if (joy1_cs)
				bus_rdata = {open_bus[7:5], joypad1_data};   // Top bits float
			else if (joy2_cs)
				bus_rdata = {open_bus[7:5], joypad2_data};
			else
				bus_rdata = open_bus;   // No APU behind this range
		end else begin
			bus_rdata = mem_rdata;
		end
	end

	// Only one pad is clocked in any bus cycle, CPU or DMA
	a_one_pad_clock: assert property (@(posedge clk) disable iff (reset)
		$onehot0(joypad_clock))
		else $error("both joypad clocks high");

endmodule

/* src/nes_bus_top.sv */
// CPU side bus core without CPU PPU APU or mapper which stay outside and are reached through these ports
`timescale 1ns/1ns

module nes_bus_top (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_bus_pkg::cpu_bus_t cpu_bus,        // External CPU cycle
	input  logic [7:0]            mem_rdata,      // Memory read data
	input  logic                  dmc_req,        // Held until dmc_ack
	input  logic [15:0]           dmc_addr,
	input  logic [4:0]            joypad1_data,
	input  logic [4:0]            joypad2_data,
	input  logic [1:0]            sys_type,       // Bit 0 selects PAL
	output nes_bus_pkg::cpu_bus_t mem_bus,        // Bus after ownership
	output logic [7:0]            cpu_rdata,
	output logic                  pause_cpu,      // CPU ready low
	output logic                  dmc_ack,
	output nes_bus_pkg::timing_t  timing,
	output logic [2:0]            joypad_out,
	output logic [1:0]            joypad_clock
);

	nes_bus_pkg::dma_bus_t dma;            // DMA request to the arbiter
	logic                  sprite_trigger; // $4014 write strobe
	logic [7:0]            bus_rdata;      // Muxed read data

	cycle_timer u_cycle_timer (
		.clk      (clk),
		.reset    (reset),
		.sys_type (sys_type),
		.timing   (timing)
	);

	dma_engine u_dma_engine (
		.clk            (clk),
		.reset          (reset),
		.timing         (timing),
		.sprite_trigger (sprite_trigger),
		.cpu_rnw        (cpu_bus.rnw),     // Raw CPU direction, not the owned one
		.cpu_wdata      (cpu_bus.wdata),   // Page byte of the $4014 write
		.bus_rdata      (bus_rdata),
		.dmc_req        (dmc_req),
		.dmc_addr       (dmc_addr),
		.dma            (dma),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	cpu_bus_arbiter u_cpu_bus_arbiter (
		.clk            (clk),
		.reset          (reset),
		.cpu_bus        (cpu_bus),
		.dma            (dma),
		.mem_rdata      (mem_rdata),
		.joypad1_data   (joypad1_data),
		.joypad2_data   (joypad2_data),
		.mem_bus        (mem_bus),
		.bus_rdata      (bus_rdata),
		.sprite_trigger (sprite_trigger),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

	assign cpu_rdata = bus_rdata;   // CPU sees the same byte the DMA latches

endmodule

/* bench/tb_vectors.svh */
// Scenario table for the bus core bench, each row runs one behavior on the DUT in NTSC unless sys says PAL
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Row kinds
localparam int K_SPACING    = 0;   // data = gaps to measure, exp = long gap length
localparam int K_JOY_WR     = 1;   // addr = strobe reg, data = byte, exp = joypad_out
localparam int K_JOY_RD     = 2;   // data = low byte of prior read, exp = joypad_clock
localparam int K_OPEN       = 3;   // data = low byte of prior read
localparam int K_SPRITE     = 4;   // Plain sprite DMA
localparam int K_SPRITE_DMC = 5;   // addr = DMC address, data = writes before the DMC request

typedef struct packed {
	logic [3:0]  kind;
	logic [15:0] addr;
	logic [7:0]  data;
	logic [1:0]  sys;    // Bit 0 selects PAL
	logic [7:0]  exp;
} vec_t;

vec_t vectors [0:15];
int   n_vec;

task add_vec(input int kind, input logic [15:0] addr, input logic [7:0] data,
		input logic [1:0] sys, input logic [7:0] exp);
	vectors[n_vec] = {kind[3:0], addr, data, sys, exp};
	n_vec++;
endtask

task load_vectors();
	n_vec = 0;
	add_vec(K_SPACING,    16'h0000, 8'd8,  2'b00, 8'd12);   // NTSC, every gap 12
	add_vec(K_JOY_WR,     16'h4016, 8'hA5, 2'b00, 8'h05);
	add_vec(K_JOY_WR,     16'h4016, 8'h3A, 2'b00, 8'h02);
	add_vec(K_JOY_RD,     16'h4016, 8'h11, 2'b00, 8'h01);   // Pad 1 clock
	add_vec(K_JOY_RD,     16'h4017, 8'h27, 2'b00, 8'h02);   // Pad 2 clock
	add_vec(K_OPEN,       16'h4003, 8'h42, 2'b00, 8'h00);
	add_vec(K_OPEN,       16'h4015, 8'h9C, 2'b00, 8'h00);   // APU status is gone
	add_vec(K_SPRITE,     16'h0000, 8'h00, 2'b00, 8'h00);
	add_vec(K_SPRITE_DMC, 16'hC123, 8'h40, 2'b00, 8'h00);   // DMC lands mid page
	add_vec(K_SPRITE_DMC, 16'hD3F0, 8'hF0, 2'b00, 8'h00);   // Near the end
	add_vec(K_SPACING,    16'h0000, 8'd12, 2'b01, 8'd16);   // PAL, 16 every fifth
	add_vec(K_SPACING,    16'h0000, 8'd6,  2'b00, 8'd12);   // Back to NTSC
endtask

`endif

/* bench/tb_nes_bus.sv */
// Bench for nes_bus_top with a flat 64K memory model where the CPU is modelled as whole 12 clock bus cycles
`timescale 1ns/1ns

module tb_nes_bus;

	localparam int GAP_NTSC = 12;   // Master clocks per CPU cycle
	localparam int PPU_GAP  = 4;    // Master clocks per PPU cycle

	logic                  clk;
	logic                  reset;
	nes_bus_pkg::cpu_bus_t cpu_bus;
	logic [7:0]            mem_rdata;
	logic                  dmc_req;
	logic [15:0]           dmc_addr;
	logic [4:0]            joypad1_data;
	logic [4:0]            joypad2_data;
	logic [1:0]            sys_type;
	nes_bus_pkg::cpu_bus_t mem_bus;
	logic [7:0]            cpu_rdata;
	logic                  pause_cpu;
	logic                  dmc_ack;
	nes_bus_pkg::timing_t  timing;
	logic [2:0]            joypad_out;
	logic [1:0]            joypad_clock;

	logic [7:0]            mem [0:65535];
	nes_bus_pkg::cpu_bus_t s_bus;     // Bus seen at the end of the last CPU cycle
	logic [7:0]            s_rdata;
	logic [1:0]            s_clock;
	int                    seed_val;

	`include "tb_vectors.svh"

	nes_bus_top u_nes_bus_top (.*);

	assign mem_rdata = mem[mem_bus.addr];   // Memory answers any owned address

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
			$display("Checks failed");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	task fail_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("Checks failed");
		$fatal(1, "Stopped on a timeout");
	endtask

	// Stops at the negedge inside the next cpu_ce clock
	task wait_ce();
		int n;
		n = 0;
		@(negedge clk);
		while (!timing.cpu_ce) begin
			n++;
			if (n > 40)
				fail_timeout("cpu_ce");
			@(negedge clk);
		end
	endtask

	task next_cycle();
		@(posedge clk);
		#10;
	endtask

	task set_idle();
		cpu_bus.addr  = 16'h0100;   // Harmless stack read
		cpu_bus.wdata = 8'h00;
		cpu_bus.rnw   = 1'b1;
	endtask

	// One CPU bus cycle from start to end, then back to idle
	task cpu_cycle(input logic [15:0] a, input logic [7:0] d, input logic rnw);
		cpu_bus.addr  = a;
		cpu_bus.wdata = d;
		cpu_bus.rnw   = rnw;
		wait_ce();
		s_bus   = mem_bus;
		s_rdata = cpu_rdata;
		s_clock = joypad_clock;
		check_eq(s_bus, {a, d, rnw}, "CPU cycle on the memory bus");   // CPU owns an idle bus
		next_cycle();
		set_idle();
	endtask

	task run_spacing(input vec_t v);
		int n;
		int i;
		int since_ppu;
		logic prev_odd;
		sys_type = v.sys;   // A change realigns both dividers
		wait_ce();
		check_eq(timing.ppu_ce, 1'b1, "ppu_ce aligned with cpu_ce");
		since_ppu = 0;
		prev_odd = timing.odd_cycle;
		for (i = 0; i < v.data; i++) begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
				since_ppu++;
				if (timing.ppu_ce) begin
					check_eq(since_ppu, PPU_GAP, "ppu_ce spacing");
					since_ppu = 0;
				end
				if (n > 40)
					fail_timeout("next cpu_ce");
			end while (!timing.cpu_ce);
			// Fifth cycle of each PAL group runs long
			check_eq(n, (v.sys[0] && i % 5 == 3) ? v.exp : GAP_NTSC, "cpu_ce spacing");
			check_eq(timing.ppu_ce, 1'b1, "ppu_ce with cpu_ce");
			check_eq(timing.odd_cycle, !prev_odd, "odd_cycle toggle");
			prev_odd = timing.odd_cycle;
		end
		next_cycle();
	endtask

	task run_joy_read(input vec_t v);
		logic [15:0] prior;
		prior = {8'h03, v.data};
		cpu_cycle(prior, 8'h00, 1'b1);   // Leaves a known byte on the bus
		cpu_cycle(v.addr, 8'h00, 1'b1);
		check_eq(s_rdata, {mem[prior][7:5], (v.addr == 16'h4016) ? joypad1_data : joypad2_data},
			"joypad read data");
		check_eq(s_clock, v.exp, "joypad_clock during read");
		@(negedge clk);
		check_eq(joypad_clock, 2'b00, "joypad_clock after read");
		wait_ce();
		next_cycle();
	endtask

	task run_sprite(input vec_t v, input logic use_dmc);
		logic [7:0] page;
		int         k;
		int         n;
		logic       pending;
		logic       dmc_seen;
		logic       raised;
		page     = 8'h02 + ($urandom % 62);   // Outside the APU page and the idle page
		dmc_addr = v.addr;
		k        = 0;
		n        = 0;
		pending  = 1'b0;
		dmc_seen = 1'b0;
		raised   = 1'b0;
		cpu_cycle(16'h4014, page, 1'b0);
		check_eq(pause_cpu, 1'b1, "pause_cpu after the page write");
		while (k < 256) begin
			wait_ce();
			n++;
			if (n > 800)
				fail_timeout("end of sprite DMA");
			check_eq(pause_cpu, 1'b1, "pause_cpu during DMA");
			if (dmc_ack) begin
				check_eq(timing.odd_cycle, 1'b0, "dmc_ack parity");
				check_eq(mem_bus.addr, v.addr, "DMC address on the bus");
				check_eq(mem_bus.rnw, 1'b1, "DMC cycle direction");
				check_eq(pending, 1'b0, "DMC cut a read and write pair");
				dmc_seen = 1'b1;
			end else if (mem_bus.rnw && mem_bus.addr[15:8] == page) begin
				check_eq(mem_bus.addr[7:0], k[7:0], "sprite read offset");
				check_eq(pending, 1'b0, "two sprite reads in a row");
				check_eq(timing.odd_cycle, 1'b0, "sprite read parity");
				check_eq(cpu_rdata, mem[{page, k[7:0]}], "sprite read data");
				pending = 1'b1;
			end else if (!mem_bus.rnw && mem_bus.addr == 16'h2004) begin
				check_eq(pending, 1'b1, "sprite write without read");
				check_eq(mem_bus.wdata, mem[{page, k[7:0]}], "sprite write data");
				pending = 1'b0;
				k++;
			end else begin
				check_eq(mem_bus.addr, 16'h0100, "idle cycle address");
				check_eq(pending, 1'b0, "write missing after read");
			end
			next_cycle();
			if (dmc_seen)
				dmc_req = 1'b0;   // Requester drops after the ack
			if (use_dmc && !raised && k == v.data) begin
				dmc_req = 1'b1;
				raised  = 1'b1;
			end
		end
		check_eq(pause_cpu, 1'b0, "pause_cpu after the last write");
		check_eq(dmc_seen, use_dmc, "DMC fetch seen");
	endtask

	initial begin
		seed_val = $urandom(16692);
		for (int i = 0; i < 65536; i++)
			mem[i] = $urandom ^ i[15:8] ^ i[7:0];
		joypad1_data = $urandom;
		joypad2_data = $urandom;
		reset    = 1'b1;
		dmc_req  = 1'b0;
		dmc_addr = 16'h0000;
		sys_type = 2'b00;
		set_idle();
		load_vectors();

		repeat (5) @(posedge clk);
		#10;
		reset = 1'b0;
		check_eq({pause_cpu, dmc_ack, joypad_out, joypad_clock}, 0, "outputs after reset");
		check_eq({timing.odd_cycle, timing.cpu_reset}, 2'b11, "timing after reset");
		wait_ce();
		next_cycle();
		check_eq(timing.cpu_reset, 1'b0, "cpu_reset after first tick");

		for (int i = 0; i < n_vec; i++) begin
			case (vectors[i].kind)
				K_SPACING: run_spacing(vectors[i]);
				K_JOY_WR: begin
					cpu_cycle(vectors[i].addr, vectors[i].data, 1'b0);
					check_eq(joypad_out, vectors[i].exp, "joypad_out after strobe write");
				end
				K_JOY_RD: run_joy_read(vectors[i]);
				K_OPEN: begin
					cpu_cycle({8'h03, vectors[i].data}, 8'h00, 1'b1);
					cpu_cycle(vectors[i].addr, 8'h00, 1'b1);
					check_eq(s_rdata, mem[{8'h03, vectors[i].data}], "open bus read");
				end
				K_SPRITE:     run_sprite(vectors[i], 1'b0);
				K_SPRITE_DMC: run_sprite(vectors[i], 1'b1);
				default:      check_eq(vectors[i].kind, 0, "unknown row kind");
			endcase
		end

		$display("All checks passed");
		$finish;
	end

endmodule

/* list.f */
+incdir+bench
src/nes_bus_pkg.sv
src/cycle_timer.sv
src/dma_engine.sv
src/cpu_bus_arbiter.sv
src/nes_bus_top.sv
bench/tb_nes_bus.sv

/* Bender.yml */
package:
  name: nes_bus

sources:
  - src/nes_bus_pkg.sv
  - src/cycle_timer.sv
  - src/dma_engine.sv
  - src/cpu_bus_arbiter.sv
  - src/nes_bus_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_nes_bus.sv
